// ==== design/pcie_chan_pkg.sv ====
`default_nettype none

package pcie_chan_pkg;

  // Word and sideband widths
  localparam int WORD_W    = 32;
  localparam int KEEP_W    = 4;
  localparam int COUNT_W   = 24;
  localparam int BAR_HIT_W = 7;

  // BAR decode and configuration space layout
  localparam int NUM_BARS     = 6;
  localparam int BAR_CTRL_BIT = 0;
  localparam int BAR_DATA_BIT = 1;
  localparam int CFG_ADDR_W   = 10;
  localparam logic [CFG_ADDR_W-1:0] CFG_BAR0_DWADDR = 10'd4;

  typedef struct packed {
    logic [WORD_W-1:0] data;
    logic [KEEP_W-1:0] keep;
    logic              last;
  } pcie_beat_t;

  // Ping-pong FIFO write side
  typedef struct packed {
    logic [1:0]        activate;
    logic              strobe;
    logic [WORD_W-1:0] data;
  } ppfifo_wr_req_t;

  typedef struct packed {
    logic [1:0]         ready;
    logic [COUNT_W-1:0] size;
  } ppfifo_wr_stat_t;

  // Ping-pong FIFO read side
  typedef struct packed {
    logic activate;
    logic strobe;
  } ppfifo_rd_req_t;

  typedef struct packed {
    logic               ready;
    logic [COUNT_W-1:0] count;
    logic [WORD_W-1:0]  data;
  } ppfifo_rd_stat_t;

  typedef logic [NUM_BARS-1:0][WORD_W-1:0] bar_addr_t;

endpackage

`default_nettype wire

// ==== design/ppfifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module ppfifo
  import pcie_chan_pkg::*;
#(
  parameter int ADDR_W = 5
) (
  input  logic            clk,
  input  logic            i_rst_n,
  input  ppfifo_wr_req_t  i_wr,
  output ppfifo_wr_stat_t o_wr,
  input  ppfifo_rd_req_t  i_rd,
  output ppfifo_rd_stat_t o_rd
);

  localparam int DEPTH = 2 ** ADDR_W;

  logic [WORD_W-1:0]     mem [2][DEPTH];
  logic [1:0][ADDR_W:0]  bank_cnt;
  logic [1:0]            committed;
  logic                  older;

  logic [1:0]            wr_act_q;
  logic [ADDR_W:0]       wr_ptr;
  logic                  wr_bank;
  logic                  wr_en;

  logic                  rd_act_q;
  logic                  rd_own;
  logic                  rd_bank;
  logic [ADDR_W:0]       rd_ptr;
  logic                  rd_sel;
  logic                  rd_cur;
  logic                  rd_release;

  // Bank 0 wins if a writer ever raises both
  assign wr_bank = i_wr.activate[1] & ~i_wr.activate[0];
  assign wr_en   = i_wr.strobe && (|i_wr.activate) && !wr_ptr[ADDR_W];

  // A bank is free only when nothing is in it and no writer holds it
  assign o_wr.ready = ~committed & ~wr_act_q & ~i_wr.activate;
  assign o_wr.size  = COUNT_W'(DEPTH);

  // Oldest committed bank is offered first
  assign rd_sel     = (committed == 2'b11) ? older : committed[1];
  assign rd_cur     = rd_act_q ? rd_bank : rd_sel;
  assign rd_release = rd_act_q && !i_rd.activate && rd_own;

  assign o_rd.ready = committed[rd_sel] && !rd_act_q && !i_rd.activate;
  assign o_rd.count = COUNT_W'(bank_cnt[rd_cur]);
  assign o_rd.data  = mem[rd_cur][rd_ptr[ADDR_W-1:0]];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_bank][wr_ptr[ADDR_W-1:0]] <= i_wr.data;
    end
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_act_q  <= '0;
      wr_ptr    <= '0;
      committed <= '0;
      bank_cnt  <= '0;
      older     <= 1'b0;
      rd_act_q  <= 1'b0;
      rd_own    <= 1'b0;
      rd_bank   <= 1'b0;
      rd_ptr    <= '0;
    end else begin
      wr_act_q <= i_wr.activate;
      rd_act_q <= i_rd.activate;

      if (i_wr.activate == 2'b00) begin
        wr_ptr <= '0;
      end else if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end

      // Falling activate closes the bank, empty banks stay free
      for (int b = 0; b < 2; b++) begin
        if (wr_act_q[b] && !i_wr.activate[b] && (wr_ptr != '0)) begin
          committed[b] <= 1'b1;
          bank_cnt[b]  <= wr_ptr;
          if (!committed[1-b]) begin
            older <= 1'(b);
          end
        end
      end

      if (i_rd.activate && !rd_act_q) begin
        rd_bank <= rd_sel;
        rd_own  <= committed[rd_sel];
      end

      if (!i_rd.activate) begin
        rd_ptr <= '0;
      end else if (i_rd.strobe && (rd_ptr < bank_cnt[rd_cur])) begin
        rd_ptr <= rd_ptr + 1'b1;
      end

      // Other bank becomes the oldest once this one is freed
      if (rd_release) begin
        committed[rd_bank] <= 1'b0;
        older              <= ~rd_bank;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/stream_to_ppfifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_to_ppfifo
  import pcie_chan_pkg::*;
(
  input  logic            clk,
  input  logic            i_rst_n,
  input  logic            i_valid,
  input  pcie_beat_t      i_beat,
  output logic            o_ready,
  output ppfifo_wr_req_t  o_wr,
  input  ppfifo_wr_stat_t i_wr
);

  logic [1:0]         bank_act;
  logic [COUNT_W-1:0] word_cnt;
  logic               accept;
  logic               close;

  // Beats flow only into an active bank
  assign o_ready = |bank_act;
  assign accept  = i_valid && o_ready;

  // End of packet or bank full
  assign close = accept && (i_beat.last || ((word_cnt + 1'b1) >= i_wr.size));

  assign o_wr.activate = bank_act;
  assign o_wr.strobe   = accept;
  assign o_wr.data     = i_beat.data;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      bank_act <= '0;
      word_cnt <= '0;
    end else if (bank_act == 2'b00) begin
      word_cnt <= '0;
      // Prefer bank 0 when both are free
      if (i_wr.ready[0]) begin
        bank_act <= 2'b01;
      end else if (i_wr.ready[1]) begin
        bank_act <= 2'b10;
      end
    end else if (close) begin
      bank_act <= '0;
    end else if (accept) begin
      word_cnt <= word_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== design/ppfifo_to_stream.sv ====
`timescale 1ns/1ps
`default_nettype none

module ppfifo_to_stream
  import pcie_chan_pkg::*;
(
  input  logic            clk,
  input  logic            i_rst_n,
  output ppfifo_rd_req_t  o_rd,
  input  ppfifo_rd_stat_t i_rd,
  output logic            o_valid,
  output pcie_beat_t      o_beat,
  input  logic            i_ready
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LATCH,
    ST_CHECK,
    ST_STREAM
  } state_t;

  state_t             state;
  logic               rd_act;
  logic [COUNT_W-1:0] word_total;
  logic [COUNT_W-1:0] word_idx;
  logic               last_word;
  logic               fire;

  assign o_valid   = (state == ST_STREAM);
  assign fire      = o_valid && i_ready;
  assign last_word = (word_idx == (word_total - 1'b1));

  // Read data is already the current word while the bank is held
  assign o_beat.data = i_rd.data;
  assign o_beat.keep = '1;
  assign o_beat.last = last_word;

  assign o_rd.activate = rd_act;
  assign o_rd.strobe   = fire;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state      <= ST_IDLE;
      rd_act     <= 1'b0;
      word_total <= '0;
      word_idx   <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (i_rd.ready) begin
            rd_act <= 1'b1;
            state  <= ST_LATCH;
          end
        end
        ST_LATCH: begin
          word_total <= i_rd.count;
          word_idx   <= '0;
          state      <= ST_CHECK;
        end
        ST_CHECK: begin
          // Nothing to send, hand the bank straight back
          if (word_total == '0) begin
            rd_act <= 1'b0;
            state  <= ST_IDLE;
          end else begin
            state <= ST_STREAM;
          end
        end
        default: begin
          if (fire) begin
            word_idx <= word_idx + 1'b1;
            if (last_word) begin
              rd_act <= 1'b0;
              state  <= ST_IDLE;
            end
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/bar_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module bar_router
  import pcie_chan_pkg::*;
(
  input  logic                 i_rx_valid,
  input  pcie_beat_t           i_rx_beat,
  input  logic [BAR_HIT_W-1:0] i_rx_bar_hit,
  output logic                 o_rx_ready,
  output logic                 o_ctrl_valid,
  output logic                 o_data_valid,
  output pcie_beat_t           o_rx_fwd_beat,
  input  logic                 i_ctrl_ready,
  input  logic                 i_data_ready,
  input  logic                 i_ctrl_eg_valid,
  input  pcie_beat_t           i_ctrl_eg_beat,
  output logic                 o_ctrl_eg_ready,
  input  logic                 i_data_eg_valid,
  input  pcie_beat_t           i_data_eg_beat,
  output logic                 o_data_eg_ready,
  output logic                 o_tx_valid,
  output pcie_beat_t           o_tx_beat,
  input  logic                 i_tx_ready,
  input  logic                 clk,
  input  logic                 i_rst_n
);

  logic ctrl_hit;
  logic data_hit;
  logic pkt_open;
  logic grant_data;
  logic sel_data;

  // Control BAR takes priority if both bits are set
  assign ctrl_hit = i_rx_bar_hit[BAR_CTRL_BIT];
  assign data_hit = !ctrl_hit && i_rx_bar_hit[BAR_DATA_BIT];

  assign o_ctrl_valid  = i_rx_valid && ctrl_hit;
  assign o_data_valid  = i_rx_valid && data_hit;
  assign o_rx_fwd_beat = i_rx_beat;

  // Unmapped beats are swallowed
  assign o_rx_ready = ctrl_hit ? i_ctrl_ready : (data_hit ? i_data_ready : 1'b1);

  // Control first at a packet boundary, then locked until last
  assign sel_data = pkt_open ? grant_data : !i_ctrl_eg_valid;

  assign o_tx_valid      = sel_data ? i_data_eg_valid : i_ctrl_eg_valid;
  assign o_tx_beat       = sel_data ? i_data_eg_beat : i_ctrl_eg_beat;
  assign o_ctrl_eg_ready = !sel_data && i_tx_ready;
  assign o_data_eg_ready = sel_data && i_tx_ready;

  // Lock as soon as a beat is presented so tx valid stays stable
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pkt_open   <= 1'b0;
      grant_data <= 1'b0;
    end else if (o_tx_valid && i_tx_ready && o_tx_beat.last) begin
      pkt_open <= 1'b0;
    end else if (o_tx_valid) begin
      pkt_open   <= 1'b1;
      grant_data <= sel_data;
    end
  end

endmodule

`default_nettype wire

// ==== design/bar_config_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module bar_config_reader
  import pcie_chan_pkg::*;
(
  input  logic                  clk,
  input  logic                  i_rst_n,
  input  logic                  i_read_bar_stb,
  output logic                  o_cfg_rd_en,
  output logic [CFG_ADDR_W-1:0] o_cfg_dwaddr,
  input  logic [WORD_W-1:0]     i_cfg_do,
  input  logic                  i_cfg_rd_wr_done,
  output bar_addr_t             o_bar_addr,
  output logic                  o_bar_busy
);

  localparam int IDX_W = $clog2(NUM_BARS);

  logic [IDX_W-1:0] bar_idx;

  // BAR n lives at dword BAR0 + n
  assign o_cfg_dwaddr = CFG_BAR0_DWADDR + CFG_ADDR_W'(bar_idx);

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      bar_idx     <= '0;
      o_cfg_rd_en <= 1'b0;
      o_bar_busy  <= 1'b0;
      o_bar_addr  <= '0;
    end else begin
      o_cfg_rd_en <= 1'b0;
      if (!o_bar_busy) begin
        if (i_read_bar_stb) begin
          bar_idx     <= '0;
          o_bar_busy  <= 1'b1;
          o_cfg_rd_en <= 1'b1;
        end
      end else if (i_cfg_rd_wr_done && !o_cfg_rd_en) begin
        o_bar_addr[bar_idx] <= i_cfg_do;
        if (bar_idx == IDX_W'(NUM_BARS - 1)) begin
          o_bar_busy <= 1'b0;
        end else begin
          // Next dword goes out only after this one answered
          bar_idx     <= bar_idx + 1'b1;
          o_cfg_rd_en <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/pcie_chan_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pcie_chan_top
  import pcie_chan_pkg::*;
#(
  parameter int CTRL_ADDR_W = 5,
  parameter int DATA_ADDR_W = 7
) (
  input  logic                  clk,
  input  logic                  i_rst_n,
  input  logic                  i_rx_valid,
  input  pcie_beat_t            i_rx_beat,
  input  logic [BAR_HIT_W-1:0]  i_rx_bar_hit,
  output logic                  o_rx_ready,
  output logic                  o_tx_valid,
  output pcie_beat_t            o_tx_beat,
  input  logic                  i_tx_ready,
  input  ppfifo_rd_req_t        i_ctrl_in_rd,
  output ppfifo_rd_stat_t       o_ctrl_in_rd,
  input  ppfifo_rd_req_t        i_data_in_rd,
  output ppfifo_rd_stat_t       o_data_in_rd,
  input  ppfifo_wr_req_t        i_ctrl_out_wr,
  output ppfifo_wr_stat_t       o_ctrl_out_wr,
  input  ppfifo_wr_req_t        i_data_out_wr,
  output ppfifo_wr_stat_t       o_data_out_wr,
  input  logic                  i_read_bar_stb,
  output logic                  o_cfg_rd_en,
  output logic [CFG_ADDR_W-1:0] o_cfg_dwaddr,
  input  logic [WORD_W-1:0]     i_cfg_do,
  input  logic                  i_cfg_rd_wr_done,
  output bar_addr_t             o_bar_addr,
  output logic                  o_bar_busy
);

  // Ingress streams after BAR steering
  logic            ctrl_in_valid;
  logic            data_in_valid;
  logic            ctrl_in_ready;
  logic            data_in_ready;
  pcie_beat_t      rx_fwd_beat;

  logic            ctrl_eg_valid;
  logic            data_eg_valid;
  logic            ctrl_eg_ready;
  logic            data_eg_ready;
  pcie_beat_t      ctrl_eg_beat;
  pcie_beat_t      data_eg_beat;

  // Adapter side of the four FIFOs
  ppfifo_wr_req_t  ctrl_in_wr_req;
  ppfifo_wr_stat_t ctrl_in_wr_stat;
  ppfifo_wr_req_t  data_in_wr_req;
  ppfifo_wr_stat_t data_in_wr_stat;
  ppfifo_rd_req_t  ctrl_out_rd_req;
  ppfifo_rd_stat_t ctrl_out_rd_stat;
  ppfifo_rd_req_t  data_out_rd_req;
  ppfifo_rd_stat_t data_out_rd_stat;

  bar_router bar_router_i (
    .i_rx_valid      (i_rx_valid),
    .i_rx_beat       (i_rx_beat),
    .i_rx_bar_hit    (i_rx_bar_hit),
    .o_rx_ready      (o_rx_ready),
    .o_ctrl_valid    (ctrl_in_valid),
    .o_data_valid    (data_in_valid),
    .o_rx_fwd_beat   (rx_fwd_beat),
    .i_ctrl_ready    (ctrl_in_ready),
    .i_data_ready    (data_in_ready),
    .i_ctrl_eg_valid (ctrl_eg_valid),
    .i_ctrl_eg_beat  (ctrl_eg_beat),
    .o_ctrl_eg_ready (ctrl_eg_ready),
    .i_data_eg_valid (data_eg_valid),
    .i_data_eg_beat  (data_eg_beat),
    .o_data_eg_ready (data_eg_ready),
    .o_tx_valid      (o_tx_valid),
    .o_tx_beat       (o_tx_beat),
    .i_tx_ready      (i_tx_ready),
    .clk             (clk),
    .i_rst_n         (i_rst_n)
  );

  // Control channel
  stream_to_ppfifo ctrl_s2p_i (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_valid (ctrl_in_valid),
    .i_beat  (rx_fwd_beat),
    .o_ready (ctrl_in_ready),
    .o_wr    (ctrl_in_wr_req),
    .i_wr    (ctrl_in_wr_stat)
  );

  ppfifo #(
    .ADDR_W (CTRL_ADDR_W)
  ) ctrl_ingress_i (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_wr    (ctrl_in_wr_req),
    .o_wr    (ctrl_in_wr_stat),
    .i_rd    (i_ctrl_in_rd),
    .o_rd    (o_ctrl_in_rd)
  );

  ppfifo #(
    .ADDR_W (CTRL_ADDR_W)
  ) ctrl_egress_i (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_wr    (i_ctrl_out_wr),
    .o_wr    (o_ctrl_out_wr),
    .i_rd    (ctrl_out_rd_req),
    .o_rd    (ctrl_out_rd_stat)
  );

  ppfifo_to_stream ctrl_p2s_i (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .o_rd    (ctrl_out_rd_req),
    .i_rd    (ctrl_out_rd_stat),
    .o_valid (ctrl_eg_valid),
    .o_beat  (ctrl_eg_beat),
    .i_ready (ctrl_eg_ready)
  );

  // Data channel
  stream_to_ppfifo data_s2p_i (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_valid (data_in_valid),
    .i_beat  (rx_fwd_beat),
    .o_ready (data_in_ready),
    .o_wr    (data_in_wr_req),
    .i_wr    (data_in_wr_stat)
  );

  ppfifo #(
    .ADDR_W (DATA_ADDR_W)
  ) data_ingress_i (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_wr    (data_in_wr_req),
    .o_wr    (data_in_wr_stat),
    .i_rd    (i_data_in_rd),
    .o_rd    (o_data_in_rd)
  );

  ppfifo #(
    .ADDR_W (DATA_ADDR_W)
  ) data_egress_i (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_wr    (i_data_out_wr),
    .o_wr    (o_data_out_wr),
    .i_rd    (data_out_rd_req),
    .o_rd    (data_out_rd_stat)
  );

  ppfifo_to_stream data_p2s_i (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .o_rd    (data_out_rd_req),
    .i_rd    (data_out_rd_stat),
    .o_valid (data_eg_valid),
    .o_beat  (data_eg_beat),
    .i_ready (data_eg_ready)
  );

  bar_config_reader bar_config_reader_i (
    .clk              (clk),
    .i_rst_n          (i_rst_n),
    .i_read_bar_stb   (i_read_bar_stb),
    .o_cfg_rd_en      (o_cfg_rd_en),
    .o_cfg_dwaddr     (o_cfg_dwaddr),
    .i_cfg_do         (i_cfg_do),
    .i_cfg_rd_wr_done (i_cfg_rd_wr_done),
    .o_bar_addr       (o_bar_addr),
    .o_bar_busy       (o_bar_busy)
  );

endmodule

`default_nettype wire

// ==== test/pcie_chan_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module pcie_chan_checker
  import pcie_chan_pkg::*;
(
  input  logic            clk,
  input  logic            i_rst_n,
  input  logic            i_tx_valid,
  input  pcie_beat_t      i_tx_beat,
  input  logic            i_tx_ready,
  input  ppfifo_rd_req_t  i_ctrl_rd_req,
  input  ppfifo_rd_stat_t i_ctrl_rd_stat,
  input  ppfifo_rd_req_t  i_data_rd_req,
  input  ppfifo_rd_stat_t i_data_rd_stat,
  input  ppfifo_wr_stat_t i_ctrl_out_stat,
  input  ppfifo_wr_stat_t i_data_out_stat,
  input  logic            i_cfg_rd_en,
  input  bar_addr_t       i_bar_addr,
  input  logic            i_bar_busy,
  output int              o_errors
);

  // Bank capacities of the default top-level configuration
  localparam int CTRL_BANK_WORDS = 32;
  localparam int DATA_BANK_WORDS = 128;

  logic [WORD_W-1:0] ctrl_words [$];
  logic [WORD_W-1:0] data_words [$];
  int                ctrl_lens [$];
  int                data_lens [$];
  logic [WORD_W:0]   tx_exp [$];
  int                cfg_reads;
  logic              ctrl_act_q;
  logic              data_act_q;

  initial begin
    o_errors   = 0;
    cfg_reads  = 0;
    ctrl_act_q = 1'b0;
    data_act_q = 1'b0;
  end

  task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("CHECK FAILED at %0t ns: %s expected %h actual %h", $time, name, exp, act);
    o_errors++;
  endtask

  task automatic report_other(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    o_errors++;
  endtask

  task automatic expect_ingress_word(input int chan, input logic [WORD_W-1:0] word);
    if (chan == 0) ctrl_words.push_back(word);
    else data_words.push_back(word);
  endtask

  task automatic expect_ingress_len(input int chan, input int len);
    if (chan == 0) ctrl_lens.push_back(len);
    else data_lens.push_back(len);
  endtask

  // Last flag rides above the word
  task automatic expect_tx(input logic [WORD_W-1:0] word, input logic last);
    tx_exp.push_back({last, word});
  endtask

  function automatic int pending();
    return ctrl_words.size() + data_words.size() + ctrl_lens.size() + data_lens.size()
           + tx_exp.size();
  endfunction

  function automatic int tx_pending();
    return tx_exp.size();
  endfunction

  task automatic check_idle();
    if (i_tx_valid !== 1'b0) report_value("o_tx_valid", 0, i_tx_valid);
    if (i_ctrl_rd_stat.ready !== 1'b0) report_value("o_ctrl_in_rd.ready", 0, i_ctrl_rd_stat.ready);
    if (i_data_rd_stat.ready !== 1'b0) report_value("o_data_in_rd.ready", 0, i_data_rd_stat.ready);
    if (i_cfg_rd_en !== 1'b0) report_value("o_cfg_rd_en", 0, i_cfg_rd_en);
    if (i_bar_busy !== 1'b0) report_value("o_bar_busy", 0, i_bar_busy);
    for (int n = 0; n < NUM_BARS; n++) begin
      if (i_bar_addr[n] !== '0) report_value($sformatf("o_bar_addr[%0d]", n), 0, i_bar_addr[n]);
    end
    // Egress banks report their capacity to the host writer
    if (i_ctrl_out_stat.size !== COUNT_W'(CTRL_BANK_WORDS)) begin
      report_value("o_ctrl_out_wr.size", CTRL_BANK_WORDS, i_ctrl_out_stat.size);
    end
    if (i_data_out_stat.size !== COUNT_W'(DATA_BANK_WORDS)) begin
      report_value("o_data_out_wr.size", DATA_BANK_WORDS, i_data_out_stat.size);
    end
  endtask

  task automatic check_bar(input int n, input logic [WORD_W-1:0] exp);
    if (i_bar_addr[n] !== exp) report_value($sformatf("o_bar_addr[%0d]", n), exp, i_bar_addr[n]);
  endtask

  task automatic check_cfg_reads(input int exp);
    if (cfg_reads != exp) report_value("o_cfg_rd_en pulses", exp, cfg_reads);
  endtask

  task automatic check_read(input int chan, input ppfifo_rd_req_t req,
                            input ppfifo_rd_stat_t stat, input logic act_q);
    string pfx;
    int    exp_len;
    logic [WORD_W-1:0] exp_word;
    pfx = (chan == 0) ? "o_ctrl_in_rd" : "o_data_in_rd";
    // Count is checked on the cycle the host opens a bank
    if (req.activate && !act_q) begin
      if ((chan == 0 ? ctrl_lens.size() : data_lens.size()) == 0) begin
        report_other({"host read a bank on ", pfx, " that should not exist"});
      end else begin
        exp_len = (chan == 0) ? ctrl_lens.pop_front() : data_lens.pop_front();
        if (stat.count != exp_len) report_value({pfx, ".count"}, exp_len, stat.count);
      end
    end
    if (req.activate && req.strobe) begin
      if ((chan == 0 ? ctrl_words.size() : data_words.size()) == 0) begin
        report_other({"unexpected word read on ", pfx});
      end else begin
        exp_word = (chan == 0) ? ctrl_words.pop_front() : data_words.pop_front();
        if (stat.data !== exp_word) report_value({pfx, ".data"}, exp_word, stat.data);
      end
    end
  endtask

  always @(posedge clk) begin
    logic [WORD_W:0] exp;
    if (i_rst_n) begin
      if (i_cfg_rd_en) cfg_reads++;
      check_read(0, i_ctrl_rd_req, i_ctrl_rd_stat, ctrl_act_q);
      check_read(1, i_data_rd_req, i_data_rd_stat, data_act_q);
      if (i_tx_valid && i_tx_ready) begin
        if (tx_exp.size() == 0) begin
          report_other("transmit beat appeared with no packet expected");
        end else begin
          exp = tx_exp.pop_front();
          if (i_tx_beat.data !== exp[WORD_W-1:0]) begin
            report_value("o_tx_beat.data", exp[WORD_W-1:0], i_tx_beat.data);
          end
          if (i_tx_beat.last !== exp[WORD_W]) report_value("o_tx_beat.last", exp[WORD_W], i_tx_beat.last);
          if (i_tx_beat.keep !== 4'hf) report_value("o_tx_beat.keep", 4'hf, i_tx_beat.keep);
        end
      end
    end
    ctrl_act_q <= i_ctrl_rd_req.activate;
    data_act_q <= i_data_rd_req.activate;
  end

endmodule

`default_nettype wire

// ==== test/tb_pcie_chan_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pcie_chan_top
  import pcie_chan_pkg::*;
;

  localparam int N_RX       = 12;
  localparam int N_EG       = 6;
  localparam int STIM_WORDS = N_RX * 32 + N_EG * 64 + NUM_BARS;
  localparam real TIMEOUT_NS = (40.0 * STIM_WORDS + 2000.0) * 20.0;

  logic clk;
  logic i_rst_n;
  logic i_rx_valid;
  pcie_beat_t i_rx_beat;
  logic [BAR_HIT_W-1:0] i_rx_bar_hit;
  logic o_rx_ready;
  logic o_tx_valid;
  pcie_beat_t o_tx_beat;
  logic i_tx_ready;
  ppfifo_rd_req_t i_ctrl_in_rd;
  ppfifo_rd_stat_t o_ctrl_in_rd;
  ppfifo_rd_req_t i_data_in_rd;
  ppfifo_rd_stat_t o_data_in_rd;
  ppfifo_wr_req_t i_ctrl_out_wr;
  ppfifo_wr_stat_t o_ctrl_out_wr;
  ppfifo_wr_req_t i_data_out_wr;
  ppfifo_wr_stat_t o_data_out_wr;
  logic i_read_bar_stb;
  logic o_cfg_rd_en;
  logic [CFG_ADDR_W-1:0] o_cfg_dwaddr;
  logic [WORD_W-1:0] i_cfg_do;
  logic i_cfg_rd_wr_done;
  bar_addr_t o_bar_addr;
  logic o_bar_busy;
  int errors;
  logic rx_moved;
  logic [31:0] seed;

  pcie_chan_top pcie_chan_top_i (.*);

  pcie_chan_checker checker_i (
    .clk             (clk),
    .i_rst_n         (i_rst_n),
    .i_tx_valid      (o_tx_valid),
    .i_tx_beat       (o_tx_beat),
    .i_tx_ready      (i_tx_ready),
    .i_ctrl_rd_req   (i_ctrl_in_rd),
    .i_ctrl_rd_stat  (o_ctrl_in_rd),
    .i_data_rd_req   (i_data_in_rd),
    .i_data_rd_stat  (o_data_in_rd),
    .i_ctrl_out_stat (o_ctrl_out_wr),
    .i_data_out_stat (o_data_out_wr),
    .i_cfg_rd_en     (o_cfg_rd_en),
    .i_bar_addr      (o_bar_addr),
    .i_bar_busy      (o_bar_busy),
    .o_errors        (errors)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] next_rand();
    seed = seed ^ (seed << 13);
    seed = seed ^ (seed >> 17);
    seed = seed ^ (seed << 5);
    return seed;
  endfunction

  // Expected BAR word from the configuration-space rule
  function automatic logic [WORD_W-1:0] exp_bar(input int n);
    return 32'hb000_0000 + ((32'(CFG_BAR0_DWADDR) + n) << 4);
  endfunction

  // Packet-boundary arbitration that returns 1 when control goes out first
  function automatic logic ctrl_goes_first(input logic ctrl_pend, input logic data_pend);
    return ctrl_pend || !data_pend;
  endfunction

  always @(posedge clk) rx_moved <= i_rx_valid && o_rx_ready;

  // Configuration-space responder with random delay
  initial begin
    logic [CFG_ADDR_W-1:0] addr;
    forever begin
      @(negedge clk);
      i_cfg_rd_wr_done = 1'b0;
      if (o_cfg_rd_en) begin
        addr = o_cfg_dwaddr;
        repeat (1 + next_rand() % 4) @(negedge clk);
        i_cfg_do         = 32'hb000_0000 + (32'(addr) << 4);
        i_cfg_rd_wr_done = 1'b1;
      end
    end
  end

  always @(negedge clk) i_tx_ready = (next_rand() % 8) != 0;

  // Host readers of both ingress FIFOs
  initial begin
    int n;
    forever begin
      @(negedge clk);
      if (o_ctrl_in_rd.ready) begin
        i_ctrl_in_rd.activate = 1'b1;
        @(negedge clk);
        n = o_ctrl_in_rd.count;
        for (int k = 0; k < n; k++) begin
          i_ctrl_in_rd.strobe = 1'b1;
          @(negedge clk);
        end
        i_ctrl_in_rd = '0;
      end
    end
  end

  initial begin
    int n;
    forever begin
      @(negedge clk);
      if (o_data_in_rd.ready) begin
        i_data_in_rd.activate = 1'b1;
        @(negedge clk);
        n = o_data_in_rd.count;
        for (int k = 0; k < n; k++) begin
          i_data_in_rd.strobe = 1'b1;
          @(negedge clk);
        end
        i_data_in_rd = '0;
      end
    end
  end

  // Sends one receive packet where chan 2 selects an unmapped BAR
  task automatic send_rx_packet(input int chan, input int len);
    logic [WORD_W-1:0] word;
    i_rx_bar_hit = BAR_HIT_W'(1) << chan;
    for (int b = 0; b < len; b++) begin
      word = next_rand();
      if (chan < 2) checker_i.expect_ingress_word(chan, word);
      i_rx_valid = 1'b1;
      i_rx_beat  = '{data: word, keep: 4'hf, last: (b == len - 1)};
      @(negedge clk);
      while (!rx_moved) @(negedge clk);
    end
    if (chan < 2) checker_i.expect_ingress_len(chan, len);
    i_rx_valid = 1'b0;
  endtask

  // Fills one bank in each egress FIFO and commits both on the same cycle
  task automatic write_egress_pair(input int lc, input int ld);
    logic [WORD_W-1:0] cw [$];
    logic [WORD_W-1:0] dw [$];
    for (int k = 0; k < lc; k++) cw.push_back({4'hc, 28'(next_rand())});
    for (int k = 0; k < ld; k++) dw.push_back({4'hd, 28'(next_rand())});
    if (ctrl_goes_first(lc != 0, ld != 0)) begin
      foreach (cw[k]) checker_i.expect_tx(cw[k], k == lc - 1);
      foreach (dw[k]) checker_i.expect_tx(dw[k], k == ld - 1);
    end else begin
      foreach (dw[k]) checker_i.expect_tx(dw[k], k == ld - 1);
      foreach (cw[k]) checker_i.expect_tx(cw[k], k == lc - 1);
    end
    while (!(|o_ctrl_out_wr.ready) || !(|o_data_out_wr.ready)) @(negedge clk);
    i_ctrl_out_wr.activate = o_ctrl_out_wr.ready[0] ? 2'b01 : 2'b10;
    i_data_out_wr.activate = o_data_out_wr.ready[0] ? 2'b01 : 2'b10;
    for (int k = 0; k < ((lc > ld) ? lc : ld); k++) begin
      @(negedge clk);
      i_ctrl_out_wr.strobe = (k < lc);
      i_ctrl_out_wr.data   = (k < lc) ? cw[k] : '0;
      i_data_out_wr.strobe = (k < ld);
      i_data_out_wr.data   = (k < ld) ? dw[k] : '0;
    end
    @(negedge clk);
    i_ctrl_out_wr = '0;
    i_data_out_wr = '0;
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("Run hung: the watchdog ran out before all transfers finished");
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    int chan;
    seed = 32'he8eaa3d5;
    clk = 1'b0;
    i_rst_n = 1'b0;
    i_rx_valid = 1'b0;
    i_rx_beat = '0;
    i_rx_bar_hit = '0;
    i_tx_ready = 1'b0;
    i_ctrl_in_rd = '0;
    i_data_in_rd = '0;
    i_ctrl_out_wr = '0;
    i_data_out_wr = '0;
    i_read_bar_stb = 1'b0;
    i_cfg_do = '0;
    i_cfg_rd_wr_done = 1'b0;
    repeat (8) @(negedge clk);
    i_rst_n = 1'b1;
    @(negedge clk);
    checker_i.check_idle();

    // BAR fetch with a second strobe that lands while busy
    i_read_bar_stb = 1'b1;
    @(negedge clk);
    i_read_bar_stb = 1'b0;
    while (!o_bar_busy) @(negedge clk);
    repeat (2) @(negedge clk);
    i_read_bar_stb = 1'b1;
    @(negedge clk);
    i_read_bar_stb = 1'b0;
    while (o_bar_busy) @(negedge clk);
    repeat (10) @(negedge clk);
    checker_i.check_cfg_reads(NUM_BARS);
    for (int n = 0; n < NUM_BARS; n++) checker_i.check_bar(n, exp_bar(n));

    for (int p = 0; p < N_RX; p++) begin
      chan = (p == 1) ? 2 : int'(next_rand() % 3);
      send_rx_packet(chan, 1 + next_rand() % 32);
    end
    while (checker_i.pending() != 0) @(negedge clk);

    for (int r = 0; r < N_EG; r++) begin
      write_egress_pair(1 + next_rand() % 32, 1 + next_rand() % 32);
      while (checker_i.tx_pending() != 0) @(negedge clk);
    end
    repeat (20) @(negedge clk);

    $display("Checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== pcie_chan.f ====
design/pcie_chan_pkg.sv
design/ppfifo.sv
design/stream_to_ppfifo.sv
design/ppfifo_to_stream.sv
design/bar_router.sv
design/bar_config_reader.sv
design/pcie_chan_top.sv
test/pcie_chan_checker.sv
test/tb_pcie_chan_top.sv

// ==== Bender.yml ====
package:
  name: pcie_chan

sources:
  - design/pcie_chan_pkg.sv
  - design/ppfifo.sv
  - design/stream_to_ppfifo.sv
  - design/ppfifo_to_stream.sv
  - design/bar_router.sv
  - design/bar_config_reader.sv
  - design/pcie_chan_top.sv
  - target: test
    files:
      - test/pcie_chan_checker.sv
      - test/tb_pcie_chan_top.sv
